// File: hw/line_timing_pkg.sv
// Horizontal timing package with the pixel coordinate type and line length limits
package line_timing_pkg;

    // Bits in a horizontal pixel coordinate
    localparam int HPOS_W = 9;

    // Horizontal position within a line, 0 is the leftmost pixel
    typedef logic [HPOS_W-1:0] hpos_t;

    // Longest line that hpos_t can address
    localparam int MAX_LINE_W = 2 ** HPOS_W;

    // Each line buffer is sized for the full coordinate range
    // and a line shorter than that only uses the low part

endpackage

// File: hw/obj_types_pkg.sv
// Object pixel and sprite row formats with the transparent and blank codes
package obj_types_pkg;

    import line_timing_pkg::*;

    // Pixels in one sprite row
    localparam int OBJ_ROW_PIXELS = 8;

    // One line buffer entry
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] col;
    } obj_pixel_t;

    // One sprite row as sent by the sprite engine
    // colour[0] is the leftmost pixel when hflip is low
    typedef struct packed {
        hpos_t                           x;
        logic [3:0]                      pal;
        logic [OBJ_ROW_PIXELS-1:0][3:0]  colour;
        logic                            hflip;
    } obj_row_t;

    // Colour index that is never written
    localparam logic [3:0] OBJ_ALPHA = 4'hF;

    // Value left behind by the erase after scan-out
    // Its colour field is transparent too
    localparam obj_pixel_t OBJ_BLANK = obj_pixel_t'(8'hFF);

endpackage

// File: hw/dual_port_ram.sv
// Two-port synchronous RAM with one write port and one registered read port
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int AW = 9,
    parameter int DW = 8
) (
    input  logic          clk,
    // Write port
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    // Read port
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    // Storage, one word per address
    logic [DW-1:0] mem [2**AW];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read
    // a write to the same address in this cycle is not seen yet,
    // so the old word comes out
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: hw/obj_line_buffer.sv
// Object line buffer that drops transparent writes and erases each location after it is read
`timescale 1ns/1ps

module obj_line_buffer
    import obj_types_pkg::*, line_timing_pkg::*;
#(
    parameter int LINE_W    = 256,
    parameter int BLANK_DLY = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    // Draw side
    input  logic       wr_en,
    input  hpos_t      wr_x,
    input  obj_pixel_t wr_pix,
    // Scan side, every read is followed by an erase
    input  logic       rd,
    input  hpos_t      rd_x,
    output obj_pixel_t rd_data,
    output logic       rd_valid
);

    // Erase pipeline, one stage per cycle of delay
    logic [BLANK_DLY-1:0] er_v;
    hpos_t                er_x [BLANK_DLY];
    // Read valid follows the RAM and output register
    logic [1:0]           rd_q;
    // Port 0 controls
    logic                 draw_we;
    logic                 erase_we;
    logic                 ram_we;
    hpos_t                ram_waddr;
    obj_pixel_t           ram_wdata;
    obj_pixel_t           ram_q;

    // Transparent pixels never reach the RAM
    assign draw_we  = wr_en && (wr_pix.col != OBJ_ALPHA);
    assign erase_we = er_v[BLANK_DLY-1];

    // Erase has priority over draw on port 0
    assign ram_we    = erase_we || draw_we;
    assign ram_waddr = erase_we ? er_x[BLANK_DLY-1] : wr_x;
    assign ram_wdata = erase_we ? OBJ_BLANK : wr_pix;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            er_v <= '0;
            rd_q <= '0;
        end else begin
            er_v <= {er_v[BLANK_DLY-2:0], rd};
            rd_q <= {rd_q[0], rd};
        end
    end

    // Read address travels with its erase request
    always_ff @(posedge clk) begin
        er_x[0] <= rd_x;
        for (int i = 1; i < BLANK_DLY; i++) begin
            er_x[i] <= er_x[i-1];
        end
    end

    // Second read stage
    always_ff @(posedge clk) begin
        rd_data <= ram_q;
    end

    assign rd_valid = rd_q[1];

    dual_port_ram #(
        .AW ( $bits(hpos_t)      ),
        .DW ( $bits(obj_pixel_t) )
    ) u_ram (
        .clk   ( clk       ),
        .we    ( ram_we    ),
        .waddr ( ram_waddr ),
        .wdata ( ram_wdata ),
        .raddr ( rd_x      ),
        .rdata ( ram_q     )
    );

    // The erase must come after the read data has left the RAM
    initial begin
        assert (BLANK_DLY >= 2) else $fatal(1, "BLANK_DLY below 2");
        assert (LINE_W <= MAX_LINE_W) else $fatal(1, "LINE_W beyond coordinate range");
    end

    // Addresses stay inside the visible line
    a_wr_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> int'(wr_x) < LINE_W);
    a_rd_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        rd |-> int'(rd_x) < LINE_W);

endmodule

// File: hw/obj_pixel_drawer.sv
// Sprite row drawer that turns one accepted row into eight clipped pixel writes
`timescale 1ns/1ps

module obj_pixel_drawer
    import obj_types_pkg::*, line_timing_pkg::*;
#(
    parameter int LINE_W = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    // Sprite row input
    input  logic       sprite_valid,
    input  obj_row_t   sprite,
    output logic       sprite_ready,
    // Pixel writes towards the line buffer
    output logic       wr_en,
    output hpos_t      wr_x,
    output obj_pixel_t wr_pix
);

    // Column counter width
    localparam int CW = $clog2(OBJ_ROW_PIXELS);
    // One extra bit so that positions past the coordinate range do not wrap
    localparam int XW = $bits(hpos_t) + 1;
    localparam logic [CW-1:0] LAST_COL = CW'(OBJ_ROW_PIXELS - 1);

    obj_row_t      row;
    logic          busy;
    logic [CW-1:0] cnt;
    logic [CW-1:0] idx;
    logic [XW-1:0] col_x;

    // Busy for exactly one row worth of columns
    assign sprite_ready = !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (sprite_valid && sprite_ready) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST_COL) begin
                busy <= 1'b0;
            end
        end
    end

    // Row held for the whole draw
    always_ff @(posedge clk) begin
        if (sprite_valid && sprite_ready) begin
            row <= sprite;
        end
    end

    // Flipped rows read their colours from the right end
    assign idx = row.hflip ? (LAST_COL - cnt) : cnt;

    // Screen position of the current column
    assign col_x = XW'(row.x) + XW'(cnt);

    // Columns at or past the line end are dropped
    assign wr_en  = busy && (col_x < XW'(LINE_W));
    assign wr_x   = hpos_t'(col_x);
    assign wr_pix = '{pal: row.pal, col: row.colour[idx]};

    // Ready stays low through all columns of the row, then comes back
    a_row_window: assert property (@(posedge clk) disable iff (!rst_n)
        sprite_valid && sprite_ready |-> ##OBJ_ROW_PIXELS !sprite_ready ##1 sprite_ready);

endmodule

// File: hw/line_scanout.sv
// Raster scan-out that reads one line buffer per line and aligns position with data
`timescale 1ns/1ps

module line_scanout
    import obj_types_pkg::*, line_timing_pkg::*;
#(
    parameter int LINE_W = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       line_start,
    // Read requests to the scan bank
    output logic       rd,
    output hpos_t      rd_x,
    input  obj_pixel_t rd_data,
    input  logic       rd_valid,
    // Video pixels in raster order
    output logic       pix_valid,
    output obj_pixel_t pix,
    output hpos_t      pix_x
);

    localparam hpos_t LAST_X = hpos_t'(LINE_W - 1);

    // Address delay matching the two read stages
    hpos_t x_d1;
    hpos_t x_d2;

    // Read counter, restarts on every line start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd   <= 1'b0;
            rd_x <= '0;
        end else if (line_start) begin
            rd   <= 1'b1;
            rd_x <= '0;
        end else if (rd) begin
            if (rd_x == LAST_X) begin
                rd <= 1'b0;
            end else begin
                rd_x <= rd_x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        x_d1 <= rd_x;
        x_d2 <= x_d1;
    end

    // Raster timing, no stall
    assign pix_valid = rd_valid;
    assign pix       = rd_data;
    assign pix_x     = x_d2;

    // Returning data must line up with its read
    a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd, 2));

endmodule

// File: hw/obj_line_top.sv
// Object line stage with two alternating line buffers, sprite drawer and scan-out
`timescale 1ns/1ps

module obj_line_top
    import obj_types_pkg::*, line_timing_pkg::*;
#(
    parameter int LINE_W    = 256,
    parameter int BLANK_DLY = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    // Sprite rows
    input  logic       sprite_valid,
    input  obj_row_t   sprite,
    output logic       sprite_ready,
    // Bank swap
    input  logic       line_start,
    // Video output
    output logic       pix_valid,
    output obj_pixel_t pix,
    output hpos_t      pix_x
);

    localparam hpos_t LAST_X = hpos_t'(LINE_W - 1);

    // Bank 0 or 1 is drawn, the other one is scanned
    logic       bank_sel;
    logic       row_bank;
    // Power-up blanking sweep
    logic       sweep_busy;
    hpos_t      sweep_x;
    logic [1:0] sweep_q;
    logic       line_go;
    // Drawer side
    logic       drw_valid;
    logic       drw_ready;
    logic       drw_wr_en;
    hpos_t      drw_wr_x;
    obj_pixel_t drw_wr_pix;
    // Scan side
    logic       scan_rd;
    hpos_t      scan_rd_x;
    obj_pixel_t scan_rd_data;
    logic       scan_rd_valid;
    hpos_t      buf_rd_x;
    // Per bank
    logic [1:0] bank_wr_en;
    logic [1:0] bank_rd;
    logic [1:0] bank_rd_valid;
    obj_pixel_t bank_rd_data [2];

    // Inputs are held off until both banks are blank
    assign line_go      = line_start && !sweep_busy;
    assign drw_valid    = sprite_valid && !sweep_busy;
    assign sprite_ready = drw_ready && !sweep_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_sel   <= 1'b0;
            row_bank   <= 1'b0;
            sweep_busy <= 1'b1;
            sweep_x    <= '0;
            sweep_q    <= '1;
        end else begin
            sweep_q <= {sweep_q[0], sweep_busy};
            if (line_go) begin
                bank_sel <= !bank_sel;
            end
            // Tag follows the row even across a swap
            if (sprite_valid && sprite_ready) begin
                row_bank <= bank_sel;
            end
            if (sweep_busy) begin
                sweep_x <= sweep_x + 1'b1;
                if (sweep_x == LAST_X) begin
                    sweep_busy <= 1'b0;
                end
            end
        end
    end

    // Sweep reads both banks at once and lets the erase path blank them
    assign buf_rd_x = sweep_busy ? sweep_x : scan_rd_x;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        assign bank_wr_en[b] = drw_wr_en && (row_bank == 1'(b));
        assign bank_rd[b]    = sweep_busy || (scan_rd && (bank_sel != 1'(b)));

        obj_line_buffer #(
            .LINE_W    ( LINE_W    ),
            .BLANK_DLY ( BLANK_DLY )
        ) u_buf (
            .clk      ( clk              ),
            .rst_n    ( rst_n            ),
            .wr_en    ( bank_wr_en[b]    ),
            .wr_x     ( drw_wr_x         ),
            .wr_pix   ( drw_wr_pix       ),
            .rd       ( bank_rd[b]       ),
            .rd_x     ( buf_rd_x         ),
            .rd_data  ( bank_rd_data[b]  ),
            .rd_valid ( bank_rd_valid[b] )
        );
    end

    // Only one bank returns scan data at a time
    // sweep data is dropped two cycles after its read
    assign scan_rd_valid = (|bank_rd_valid) && !sweep_q[1];
    assign scan_rd_data  = bank_rd_valid[1] ? bank_rd_data[1] : bank_rd_data[0];

    obj_pixel_drawer #(
        .LINE_W ( LINE_W )
    ) u_drawer (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .sprite_valid ( drw_valid  ),
        .sprite       ( sprite     ),
        .sprite_ready ( drw_ready  ),
        .wr_en        ( drw_wr_en  ),
        .wr_x         ( drw_wr_x   ),
        .wr_pix       ( drw_wr_pix )
    );

    line_scanout #(
        .LINE_W ( LINE_W )
    ) u_scan (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .line_start ( line_go       ),
        .rd         ( scan_rd       ),
        .rd_x       ( scan_rd_x     ),
        .rd_data    ( scan_rd_data  ),
        .rd_valid   ( scan_rd_valid ),
        .pix_valid  ( pix_valid     ),
        .pix        ( pix           ),
        .pix_x      ( pix_x         )
    );

endmodule

// File: bench/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: bench/obj_line_tb.sv
// Testbench for the object line stage with a reference line model and checking assertions
`timescale 1ns/1ps

module obj_line_tb
    import obj_types_pkg::*, line_timing_pkg::*;
();

    localparam int LINE_W       = 256;
    localparam int BLANK_DLY    = 2;
    localparam int LINE_CYC     = LINE_W + 20;
    localparam int STRESS_LINES = 6;
    // Reset 1, draw 3, overlap 2, erase 2, clip 2, stress plus a flush line
    localparam int TOTAL_LINES  = 10 + STRESS_LINES + 1;
    // Sweep, reset and a little slack on top of the line windows
    localparam int TIMEOUT_CYC  = TOTAL_LINES * LINE_CYC + LINE_W + 100;
    localparam logic [31:0] SEED = 32'h8322a098;

    logic       clk;
    logic       rst_n;
    logic       sprite_valid;
    obj_row_t   sprite;
    logic       sprite_ready;
    logic       line_start;
    logic       pix_valid;
    obj_pixel_t pix;
    hpos_t      pix_x;

    // Reference model, line being drawn and line being scanned
    obj_pixel_t draw_line [MAX_LINE_W];
    obj_pixel_t exp_line [MAX_LINE_W];
    obj_pixel_t exp_pix;
    obj_row_t   pending [$];
    // Bookkeeping
    int         err_cnt;
    int         test_err0;
    int         tests_ok;
    int         tests_bad;
    int         pix_cnt;
    int         cyc;
    logic       in_sweep;

    tb_clock #(.PERIOD_NS(100), .RST_CYCLES(8)) clk_gen (.clk(clk), .rst_n(rst_n));

    obj_line_top #(
        .LINE_W    ( LINE_W    ),
        .BLANK_DLY ( BLANK_DLY )
    ) dut (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sprite_valid ( sprite_valid ),
        .sprite       ( sprite       ),
        .sprite_ready ( sprite_ready ),
        .line_start   ( line_start   ),
        .pix_valid    ( pix_valid    ),
        .pix          ( pix          ),
        .pix_x        ( pix_x        )
    );

    // Cycle count and valid pixels per line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc     <= 0;
            pix_cnt <= 0;
        end else begin
            cyc <= cyc + 1;
            if (line_start) begin
                pix_cnt <= 0;
            end else if (pix_valid) begin
                pix_cnt <= pix_cnt + 1;
            end
        end
    end

    // Pixels so far on this line give the position of the next one
    always_comb begin
        exp_pix = exp_line[hpos_t'(pix_cnt)];
    end

    // Every scanned pixel matches the committed line
    a_pix_value: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> pix == exp_pix)
    else begin
        err_cnt++;
        $display("FAIL t=%0t pix exp=%h got=%h at x=%0d", $time,
                 $sampled(exp_pix), $sampled(pix), $sampled(pix_cnt));
    end

    // Position starts at 0 on each line and counts up by one per pixel
    a_pix_x: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> pix_x == hpos_t'(pix_cnt))
    else begin
        err_cnt++;
        $display("FAIL t=%0t pix_x exp=%0d got=%0d", $time,
                 $sampled(pix_cnt), $sampled(pix_x));
    end

    // No video during the blanking sweep
    a_quiet_sweep: assert property (@(posedge clk) disable iff (!rst_n)
        in_sweep |-> !pix_valid)
    else begin
        err_cnt++;
        $display("FAIL t=%0t pix_valid exp=0 got=1", $time);
    end

    function automatic obj_row_t make_row(input int x, input logic [3:0] pal,
                                          input logic [31:0] cols, input logic flip);
        obj_row_t r;
        r.x      = hpos_t'(x);
        r.pal    = pal;
        // Lowest nibble is colour 0
        r.colour = cols;
        r.hflip  = flip;
        return r;
    endfunction

    // Random row, roughly one column in four transparent
    function automatic obj_row_t rand_row();
        obj_row_t r;
        r.x   = hpos_t'($urandom_range(0, LINE_W + 4));
        r.pal = 4'($urandom_range(0, 15));
        for (int i = 0; i < OBJ_ROW_PIXELS; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                r.colour[3'(i)] = OBJ_ALPHA;
            end else begin
                r.colour[3'(i)] = 4'($urandom_range(0, 14));
            end
        end
        r.hflip = 1'($urandom_range(0, 1));
        return r;
    endfunction

    // Opaque columns of an accepted row land on the draw line
    task automatic apply_row(input obj_row_t r);
        int         px;
        logic [3:0] c;
        for (int i = 0; i < OBJ_ROW_PIXELS; i++) begin
            px = int'(r.x) + i;
            c  = r.hflip ? r.colour[3'(OBJ_ROW_PIXELS - 1 - i)] : r.colour[3'(i)];
            if (px < LINE_W && c != OBJ_ALPHA) begin
                draw_line[hpos_t'(px)] = '{pal: r.pal, col: c};
            end
        end
    endtask

    // Drawn line becomes the scanned line, drawing restarts on blank
    task automatic commit_line();
        for (int i = 0; i < MAX_LINE_W; i++) begin
            exp_line[hpos_t'(i)]  = draw_line[hpos_t'(i)];
            draw_line[hpos_t'(i)] = OBJ_BLANK;
        end
    endtask

    // Hold the row until the edge that takes it
    task automatic send_row(input obj_row_t r);
        logic taken;
        taken        = 1'b0;
        sprite_valid = 1'b1;
        sprite       = r;
        while (!taken) begin
            @(negedge clk);
            taken = sprite_ready;
            @(posedge clk);
            #1;
        end
        sprite_valid = 1'b0;
        apply_row(r);
    endtask

    // Drawer idle means its last write has landed
    task automatic wait_idle();
        logic idle;
        idle = 1'b0;
        while (!idle) begin
            @(negedge clk);
            idle = sprite_ready;
            @(posedge clk);
            #1;
        end
    endtask

    // One line: swap banks, draw the pending rows, let the scan finish
    task automatic run_line();
        int       start;
        int       gap;
        obj_row_t r;
        commit_line();
        start      = cyc;
        line_start = 1'b1;
        @(posedge clk);
        #1;
        line_start = 1'b0;
        while (pending.size() > 0) begin
            r = pending.pop_front();
            send_row(r);
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        wait_idle();
        while (cyc - start < LINE_CYC) begin
            @(posedge clk);
            #1;
        end
        assert (pix_cnt == LINE_W) else begin
            err_cnt++;
            $display("FAIL t=%0t pix_cnt exp=%0d got=%0d", $time, LINE_W, pix_cnt);
        end
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    initial begin
        logic ready_seen;
        int   n_rows;
        sprite_valid = 1'b0;
        sprite       = '0;
        line_start   = 1'b0;
        err_cnt      = 0;
        test_err0    = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        in_sweep     = 1'b1;
        void'($urandom(SEED));
        for (int i = 0; i < MAX_LINE_W; i++) begin
            draw_line[hpos_t'(i)] = OBJ_BLANK;
            exp_line[hpos_t'(i)]  = OBJ_BLANK;
        end
        @(posedge rst_n);

        // Reset state, sweep then an empty line
        ready_seen = 1'b0;
        for (int i = 0; i < LINE_W + 20 && !ready_seen; i++) begin
            @(negedge clk);
            ready_seen = sprite_ready;
        end
        @(posedge clk);
        #1;
        in_sweep = 1'b0;
        assert (ready_seen) else begin
            err_cnt++;
            $display("sprite_ready did not come back after the blanking sweep");
        end
        run_line();
        finish_test("reset state");

        // Plain row, then a flipped row, each shown on the following line
        pending.push_back(make_row(20, 4'h3, 32'h7654_3210, 1'b0));
        run_line();
        pending.push_back(make_row(100, 4'hA, 32'hEDCB_A987, 1'b1));
        run_line();
        run_line();
        finish_test("draw and flip");

        // Later row on top with holes, and a fully transparent row
        pending.push_back(make_row(40, 4'h1, 32'h1111_1111, 1'b0));
        pending.push_back(make_row(44, 4'h2, 32'hF2F2_F2F2, 1'b0));
        pending.push_back(make_row(60, 4'h5, 32'hFFFF_FFFF, 1'b1));
        run_line();
        run_line();
        finish_test("transparency and overlap");

        // Second line scans the bank shown above, which must be erased
        run_line();
        run_line();
        finish_test("erase after read");

        // Rows at the line end and near the top of the coordinate range
        pending.push_back(make_row(LINE_W - 3, 4'h6, 32'h0123_4567, 1'b0));
        pending.push_back(make_row(MAX_LINE_W - 2, 4'h7, 32'h89AB_CDE0, 1'b1));
        pending.push_back(make_row(LINE_W - 8, 4'h8, 32'h3F21_F0F4, 1'b1));
        run_line();
        run_line();
        finish_test("clipping");

        // Back-to-back random rows across several lines
        for (int l = 0; l < STRESS_LINES; l++) begin
            n_rows = $urandom_range(4, 12);
            for (int k = 0; k < n_rows; k++) begin
                pending.push_back(rand_row());
            end
            run_line();
        end
        run_line();
        finish_test("random stress");

        $display("tests passed=%0d failed=%0d errors=%0d", tests_ok, tests_bad, err_cnt);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: src.f
hw/line_timing_pkg.sv
hw/obj_types_pkg.sv
hw/dual_port_ram.sv
hw/obj_line_buffer.sv
hw/obj_pixel_drawer.sv
hw/line_scanout.sv
hw/obj_line_top.sv
bench/tb_clock.sv
bench/obj_line_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the object line stage simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module obj_line_tb

./obj_dir/Vobj_line_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
